/* hdl/fpu_lane_consts.svh */
// Widths, opcodes, forwarding limits and status bit positions, included by the lane RTL.
`ifndef FPU_LANE_CONSTS_SVH
`define FPU_LANE_CONSTS_SVH

// data path
`define FU_DATA_W 68
`define FU_NBUS 4
`define FWD_W 4

// opcodes, low two bits of the logic op pick the function
`define OP_LOGIC 8'h30
`define OP_CMP_ORD 8'h40
`define OP_CMP_UNORD 8'h41

// exception enables in the control register
`define CSR_EN_LSB 11
`define EXC_W 5
`define EXC_INVALID 4

// compare flag positions
`define FLAG_LT 0
`define FLAG_EQ 1
`define FLAG_GT 2
`define FLAG_UN 3

// retire status bits above the raise field
`define RET_TRAP 5
`define RET_PERR 6

`endif

/* hdl/fpu_lane_pkg.sv */
// Shared types of the floating-point lane, imported by its RTL and by the testbench.
`include "fpu_lane_consts.svh"

package fpu_lane_pkg;

  // plain data word without parity
  typedef logic [`FU_DATA_W-1:0] fu_word_t;

  // parity bit on top of the data word
  typedef logic [`FU_DATA_W:0] bus_word_t;

  typedef logic [`FWD_W-1:0] fwd_t;

  typedef logic [7:0] op_t;

  typedef logic [31:0] csr_t;

  typedef logic [`EXC_W-1:0] raise_t;

  // one-hot lt, eq, gt, unordered
  typedef logic [3:0] flags_t;

  // perr, trap, raised bits
  typedef logic [`EXC_W+1:0] ret_t;

  typedef enum logic [1:0] {
    OPC_NONE,
    OPC_LOGIC,
    OPC_CMP
  } op_class_e;

endpackage

/* hdl/operand_forward.sv */
// Picks one operand from the result buses, their previous values or the register, and checks parity.
`timescale 1ns/10ps
`include "fpu_lane_consts.svh"

module operand_forward (
  input  logic                    clk,
  input  logic                    rst,
  input  fpu_lane_pkg::bus_word_t reg_op,
  input  fpu_lane_pkg::fwd_t      fwd,
  input  fpu_lane_pkg::fwd_t      fwd_prev,
  input  fpu_lane_pkg::bus_word_t bus0,
  input  fpu_lane_pkg::bus_word_t bus1,
  input  fpu_lane_pkg::bus_word_t bus2,
  input  fpu_lane_pkg::bus_word_t bus3,
  output fpu_lane_pkg::fu_word_t  operand,
  output logic                    par_err
);
  import fpu_lane_pkg::*;

  bus_word_t bus_now [`FU_NBUS];
  bus_word_t bus_hist [`FU_NBUS];
  bus_word_t sel_word;

  assign bus_now[0] = bus0;
  assign bus_now[1] = bus1;
  assign bus_now[2] = bus2;
  assign bus_now[3] = bus3;

  // bus values as of the previous edge
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `FU_NBUS; i++) begin
        bus_hist[i] <= '0;
      end
    end else begin
      bus_hist <= bus_now;
    end
  end

  // current code wins, then previous code, else register
  always_comb begin
    if (fwd < `FWD_W'(`FU_NBUS)) begin
      sel_word = bus_now[fwd[1:0]];
    end else if (fwd_prev < `FWD_W'(`FU_NBUS)) begin
      sel_word = bus_hist[fwd_prev[1:0]];
    end else begin
      sel_word = reg_op;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      operand <= '0;
      par_err <= 1'b0;
    end else begin
      operand <= sel_word[`FU_DATA_W-1:0];
      // a good word xors to zero over all 69 bits
      par_err <= ^sel_word;
    end
  end

endmodule

/* hdl/op_decode.sv */
// Decodes the issued opcode into the registered stage-1 controls of the lane.
`timescale 1ns/10ps
`include "fpu_lane_consts.svh"

module op_decode (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    en,
  input  fpu_lane_pkg::op_t       op,
  output logic                    s1_valid,
  output logic                    ordered,
  output fpu_lane_pkg::op_class_e s1_class,
  output logic [1:0]              logic_sel
);
  import fpu_lane_pkg::*;

  op_class_e dec_class;
  logic      dec_ordered;

  always_comb begin
    dec_class = OPC_NONE;
    dec_ordered = 1'b0;
    if ({op[7:2], 2'b00} == `OP_LOGIC) begin
      dec_class = OPC_LOGIC;
    end else if (op == `OP_CMP_ORD) begin
      dec_class = OPC_CMP;
      dec_ordered = 1'b1;
    end else if (op == `OP_CMP_UNORD) begin
      dec_class = OPC_CMP;
    end
    // anything else stays a no-op but still retires
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s1_class <= OPC_NONE;
      ordered <= 1'b0;
      logic_sel <= 2'b00;
    end else begin
      s1_valid <= en;
      if (en) begin
        s1_class <= dec_class;
        ordered <= dec_ordered;
        logic_sel <= op[1:0];
      end else begin
        s1_class <= OPC_NONE;
        ordered <= 1'b0;
        logic_sel <= 2'b00;
      end
    end
  end

endmodule

/* hdl/fp_exec.sv */
// Stage-2 execution of the lane: bitwise logic, double compare and result bus writeback with parity.
`timescale 1ns/10ps
`include "fpu_lane_consts.svh"

module fp_exec (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    s1_valid,
  input  logic                    ordered,
  input  fpu_lane_pkg::op_class_e s1_class,
  input  logic [1:0]              logic_sel,
  input  fpu_lane_pkg::fu_word_t  opa,
  input  fpu_lane_pkg::fu_word_t  opb,
  input  logic                    err_a,
  input  logic                    err_b,
  output fpu_lane_pkg::bus_word_t res_bus,
  output logic                    res_valid,
  output logic                    flags_valid,
  output logic                    s2_valid,
  output logic                    s2_err,
  output fpu_lane_pkg::flags_t    flags,
  output fpu_lane_pkg::raise_t    raise
);
  import fpu_lane_pkg::*;

  fu_word_t    logic_res;
  logic [63:0] da;
  logic [63:0] db;
  logic        nan_a;
  logic        nan_b;
  logic        unord;
  logic        cmp_eq;
  logic        cmp_lt;
  flags_t      cmp_flags;
  logic        op_err;
  logic        do_logic;
  logic        do_cmp;

  always_comb begin
    case (logic_sel)
      2'd0: logic_res = opa & opb;
      2'd1: logic_res = opa | opb;
      2'd2: logic_res = opa ^ opb;
      default: logic_res = opa & ~opb;
    endcase
  end

  // double compare on the low 64 bits
  assign da = opa[63:0];
  assign db = opb[63:0];
  assign nan_a = (&da[62:52]) && (|da[51:0]);
  assign nan_b = (&db[62:52]) && (|db[51:0]);
  assign unord = nan_a | nan_b;

  // signed zeros are equal
  assign cmp_eq = (da == db) || (da[62:0] == 63'd0 && db[62:0] == 63'd0);

  always_comb begin
    if (da[63] != db[63]) begin
      cmp_lt = da[63];
    end else if (da[63]) begin
      // both negative, larger magnitude is smaller
      cmp_lt = da[62:0] > db[62:0];
    end else begin
      cmp_lt = da[62:0] < db[62:0];
    end
  end

  always_comb begin
    cmp_flags = '0;
    if (unord) begin
      cmp_flags[`FLAG_UN] = 1'b1;
    end else if (cmp_eq) begin
      cmp_flags[`FLAG_EQ] = 1'b1;
    end else if (cmp_lt) begin
      cmp_flags[`FLAG_LT] = 1'b1;
    end else begin
      cmp_flags[`FLAG_GT] = 1'b1;
    end
  end

  // a bad operand kills the result but not the retire
  assign op_err = err_a | err_b;
  assign do_logic = s1_valid && !op_err && s1_class == OPC_LOGIC;
  assign do_cmp = s1_valid && !op_err && s1_class == OPC_CMP;

  always_ff @(posedge clk) begin
    if (rst) begin
      res_bus <= '0;
      res_valid <= 1'b0;
      flags <= '0;
      flags_valid <= 1'b0;
      raise <= '0;
      s2_valid <= 1'b0;
      s2_err <= 1'b0;
    end else begin
      res_valid <= do_logic;
      flags_valid <= do_cmp;
      s2_valid <= s1_valid;
      s2_err <= s1_valid & op_err;
      if (do_logic) begin
        res_bus <= {^logic_res, logic_res};
      end
      if (do_cmp) begin
        flags <= cmp_flags;
      end
      raise <= '0;
      raise[`EXC_INVALID] <= do_cmp & ordered & unord;
    end
  end

endmodule

/* hdl/excpt_retire.sv */
// Retire stage of the lane: masks raised exceptions with the enables and packs the status.
`timescale 1ns/10ps
`include "fpu_lane_consts.svh"

module excpt_retire (
  input  logic                 s2_valid,
  input  logic                 s2_err,
  input  fpu_lane_pkg::raise_t raise,
  input  fpu_lane_pkg::csr_t   fpcsr,
  output fpu_lane_pkg::ret_t   ret,
  output logic                 ret_en
);
  import fpu_lane_pkg::*;

  raise_t enables;
  raise_t trapped;
  logic   trap;

  // enable bit i guards raise bit i
  assign enables = fpcsr[`CSR_EN_LSB +: `EXC_W];
  assign trapped = raise & enables;
  assign trap = |trapped;

  always_comb begin
    ret = '0;
    ret[`EXC_W-1:0] = raise;
    ret[`RET_TRAP] = trap;
    ret[`RET_PERR] = s2_err;
  end

  // every issued op retires, known or not
  assign ret_en = s2_valid;

endmodule

/* hdl/fpu_lane_top.sv */
// Top level of one floating-point lane: forwarding, decode, execute and retire stages.
`timescale 1ns/10ps

module fpu_lane_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    en,
  input  fpu_lane_pkg::op_t       op,
  input  fpu_lane_pkg::bus_word_t a,
  input  fpu_lane_pkg::bus_word_t b,
  input  fpu_lane_pkg::fwd_t      fwd_a,
  input  fpu_lane_pkg::fwd_t      fwd_b,
  input  fpu_lane_pkg::fwd_t      fwd_prev_a,
  input  fpu_lane_pkg::fwd_t      fwd_prev_b,
  input  fpu_lane_pkg::bus_word_t bus0,
  input  fpu_lane_pkg::bus_word_t bus1,
  input  fpu_lane_pkg::bus_word_t bus2,
  input  fpu_lane_pkg::bus_word_t bus3,
  input  fpu_lane_pkg::csr_t      fpcsr,
  output fpu_lane_pkg::bus_word_t res_bus,
  output logic                    res_valid,
  output fpu_lane_pkg::flags_t    flags,
  output logic                    flags_valid,
  output fpu_lane_pkg::ret_t      ret,
  output logic                    ret_en
);
  import fpu_lane_pkg::*;

  fu_word_t  opa;
  fu_word_t  opb;
  logic      err_a;
  logic      err_b;
  logic      s1_valid;
  logic      ordered;
  op_class_e s1_class;
  logic [1:0] logic_sel;
  logic      s2_valid;
  logic      s2_err;
  raise_t    raise;

  // stage 1
  operand_forward fwd_a0 (
    .clk(clk),
    .rst(rst),
    .reg_op(a),
    .fwd(fwd_a),
    .fwd_prev(fwd_prev_a),
    .bus0(bus0),
    .bus1(bus1),
    .bus2(bus2),
    .bus3(bus3),
    .operand(opa),
    .par_err(err_a)
  );

  operand_forward fwd_b0 (
    .clk(clk),
    .rst(rst),
    .reg_op(b),
    .fwd(fwd_b),
    .fwd_prev(fwd_prev_b),
    .bus0(bus0),
    .bus1(bus1),
    .bus2(bus2),
    .bus3(bus3),
    .operand(opb),
    .par_err(err_b)
  );

  op_decode dec0 (
    .clk(clk),
    .rst(rst),
    .en(en),
    .op(op),
    .s1_valid(s1_valid),
    .ordered(ordered),
    .s1_class(s1_class),
    .logic_sel(logic_sel)
  );

  // stage 2
  fp_exec exec0 (
    .clk(clk),
    .rst(rst),
    .s1_valid(s1_valid),
    .ordered(ordered),
    .s1_class(s1_class),
    .logic_sel(logic_sel),
    .opa(opa),
    .opb(opb),
    .err_a(err_a),
    .err_b(err_b),
    .res_bus(res_bus),
    .res_valid(res_valid),
    .flags_valid(flags_valid),
    .s2_valid(s2_valid),
    .s2_err(s2_err),
    .flags(flags),
    .raise(raise)
  );

  excpt_retire ret0 (
    .s2_valid(s2_valid),
    .s2_err(s2_err),
    .raise(raise),
    .fpcsr(fpcsr),
    .ret(ret),
    .ret_en(ret_en)
  );

endmodule

/* tests/fpu_lane_sva.sv */
// Assertions bound to the lane top level for retire timing, strobe exclusivity and parity.
`timescale 1ns/10ps

module fpu_lane_sva (
  input logic                    clk,
  input logic                    rst,
  input logic                    en,
  input fpu_lane_pkg::bus_word_t res_bus,
  input logic                    res_valid,
  input logic                    flags_valid,
  input logic                    ret_en
);

  // every issue retires two edges later
  ret_follows_en: assert property (@(posedge clk) disable iff (rst) ret_en == $past(en, 2))
    else $error("ret_en does not follow en by two cycles");

  one_result_kind: assert property (@(posedge clk) !(res_valid && flags_valid))
    else $error("res_valid and flags_valid high together");

  res_parity: assert property (@(posedge clk) disable iff (rst)
    res_valid |-> (^res_bus) == 1'b0)
    else $error("res_bus parity is wrong while res_valid is high");

  // checked once reset has been seen at an edge
  quiet_in_reset: assert property (@(posedge clk)
    rst && $past(rst) |-> !res_valid && !flags_valid && !ret_en)
    else $error("a valid strobe is high during reset");

endmodule

bind fpu_lane_top fpu_lane_sva sva0 (
  .clk(clk),
  .rst(rst),
  .en(en),
  .res_bus(res_bus),
  .res_valid(res_valid),
  .flags_valid(flags_valid),
  .ret_en(ret_en)
);

/* tests/fpu_lane_tb.sv */
// Self-checking testbench of the lane that runs random ops and forwarding against a reference model.
`timescale 1ns/10ps
`include "fpu_lane_consts.svh"

module fpu_lane_tb;
  import fpu_lane_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int N_IDLE = 6;
  localparam int N_LOGIC = 40;
  localparam int N_FWD = 60;
  localparam int N_CMP = 40;
  localparam int N_PERR = 60;
  localparam int N_ISSUED = N_LOGIC + N_FWD + 2 * N_CMP + N_PERR;

  typedef struct {
    int        due;
    logic      res_valid;
    bus_word_t res_bus;
    logic      flags_valid;
    flags_t    flags;
    logic      ret_en;
    ret_t      ret;
  } expect_t;

  logic      clk;
  logic      rst;
  logic      en;
  op_t       op;
  bus_word_t a;
  bus_word_t b;
  fwd_t      fwd_a;
  fwd_t      fwd_b;
  fwd_t      fwd_prev_a;
  fwd_t      fwd_prev_b;
  bus_word_t bus0;
  bus_word_t bus1;
  bus_word_t bus2;
  bus_word_t bus3;
  csr_t      fpcsr;
  bus_word_t res_bus;
  logic      res_valid;
  flags_t    flags;
  logic      flags_valid;
  ret_t      ret;
  logic      ret_en;

  expect_t   exp_q[$];
  string     name_q[$];
  bus_word_t bus_next[`FU_NBUS];
  bus_word_t bus_cur[`FU_NBUS];
  bus_word_t bus_prev[`FU_NBUS];
  csr_t      csr_val;
  int        cyc = 0;
  int        word_errs = 0;
  int        flag_errs = 0;
  int        ret_errs = 0;
  int        strobe_errs = 0;

  fpu_lane_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  function automatic fu_word_t rand_data();
    logic [31:0] hi;
    logic [31:0] mid;
    logic [31:0] lo;
    hi = $urandom;
    mid = $urandom;
    lo = $urandom;
    return {hi[3:0], mid, lo};
  endfunction

  // good parity with a bit flipped now and then
  function automatic bus_word_t make_operand(input fu_word_t d, input int bad_pct);
    bus_word_t w;
    logic [6:0] pos;
    w = {^d, d};
    if ($urandom_range(0, 99) < bad_pct) begin
      pos = 7'($urandom_range(0, `FU_DATA_W));
      w[pos] = ~w[pos];
    end
    return w;
  endfunction

  // low 64 bits often a signed zero, a NaN or a relative of other
  function automatic fu_word_t rand_double(input fu_word_t other);
    fu_word_t d;
    d = rand_data();
    case ($urandom_range(0, 5))
      0: d[62:0] = '0;
      1: d[62:52] = '1;
      2: d[63:0] = other[63:0];
      3: d[63:0] = {~other[63], other[62:0]};
      default: begin
      end
    endcase
    return d;
  endfunction

  function automatic fwd_t rand_code();
    return fwd_t'($urandom_range(0, 7));
  endfunction

  function automatic op_t rand_op();
    case ($urandom_range(0, 3))
      0, 1: return `OP_LOGIC | 8'($urandom_range(0, 3));
      2: return ($urandom_range(0, 1) == 0) ? `OP_CMP_ORD : `OP_CMP_UNORD;
      default: return 8'($urandom);
    endcase
  endfunction

  function automatic bus_word_t select_src(input fwd_t code, input fwd_t prev_code,
                                           input bus_word_t reg_word);
    if (int'(code) < `FU_NBUS) begin
      return bus_cur[code[1:0]];
    end
    if (int'(prev_code) < `FU_NBUS) begin
      return bus_prev[prev_code[1:0]];
    end
    return reg_word;
  endfunction

  // expected outputs of one cycle from the lane rules
  function automatic void reference_op(input logic issue, input op_t o, input bus_word_t sa,
                                       input bus_word_t sb, input csr_t csr, output expect_t e);
    fu_word_t da;
    fu_word_t db;
    fu_word_t r;
    logic nan_a;
    logic nan_b;
    logic signed [64:0] key_a;
    logic signed [64:0] key_b;
    raise_t raised;
    e.due = 0;
    e.res_valid = 1'b0;
    e.res_bus = '0;
    e.flags_valid = 1'b0;
    e.flags = '0;
    e.ret_en = issue;
    e.ret = '0;
    da = sa[`FU_DATA_W-1:0];
    db = sb[`FU_DATA_W-1:0];
    if (!issue) begin
      return;
    end
    if ((^sa) || (^sb)) begin
      e.ret[`RET_PERR] = 1'b1;
    end else if ((o & 8'hFC) == `OP_LOGIC) begin
      case (o[1:0])
        2'd0: r = da & db;
        2'd1: r = da | db;
        2'd2: r = da ^ db;
        default: r = da & ~db;
      endcase
      e.res_valid = 1'b1;
      e.res_bus = {^r, r};
    end else if (o == `OP_CMP_ORD || o == `OP_CMP_UNORD) begin
      nan_a = da[62:52] == 11'h7FF && da[51:0] != 52'd0;
      nan_b = db[62:52] == 11'h7FF && db[51:0] != 52'd0;
      // signed magnitude as a two's complement key so both zeros meet at 0
      key_a = da[63] ? -$signed({2'b00, da[62:0]}) : $signed({2'b00, da[62:0]});
      key_b = db[63] ? -$signed({2'b00, db[62:0]}) : $signed({2'b00, db[62:0]});
      e.flags_valid = 1'b1;
      if (nan_a || nan_b) begin
        e.flags[`FLAG_UN] = 1'b1;
      end else if (key_a < key_b) begin
        e.flags[`FLAG_LT] = 1'b1;
      end else if (key_a > key_b) begin
        e.flags[`FLAG_GT] = 1'b1;
      end else begin
        e.flags[`FLAG_EQ] = 1'b1;
      end
      raised = '0;
      raised[`EXC_INVALID] = (o == `OP_CMP_ORD) && (nan_a || nan_b);
      e.ret[`EXC_W-1:0] = raised;
      e.ret[`RET_TRAP] = |(raised & csr[`CSR_EN_LSB +: `EXC_W]);
    end
  endfunction

  task automatic drive_cycle(input logic issue, input op_t o, input bus_word_t ra,
                             input bus_word_t rb, input fwd_t fa, input fwd_t fb,
                             input fwd_t pa, input fwd_t pb, input string name);
    expect_t e;
    @(posedge clk);
    bus_prev = bus_cur;
    bus_cur = bus_next;
    en <= issue;
    op <= o;
    a <= ra;
    b <= rb;
    fwd_a <= fa;
    fwd_b <= fb;
    fwd_prev_a <= pa;
    fwd_prev_b <= pb;
    bus0 <= bus_next[0];
    bus1 <= bus_next[1];
    bus2 <= bus_next[2];
    bus3 <= bus_next[3];
    reference_op(issue, o, select_src(fa, pa, ra), select_src(fb, pb, rb), csr_val, e);
    // sampled at the next edge and visible after the one after
    e.due = cyc + 3;
    exp_q.push_back(e);
    name_q.push_back(name);
  endtask

  task automatic idle_cycle(input string name);
    drive_cycle(1'b0, 8'h00, '0, '0, 4'hF, 4'hF, 4'hF, 4'hF, name);
  endtask

  task automatic drain(input string name);
    idle_cycle(name);
    while (exp_q.size() > 0) begin
      @(posedge clk);
    end
  endtask

  task automatic randomize_buses(input int bad_pct);
    for (int i = 0; i < `FU_NBUS; i++) begin
      bus_next[i] = make_operand(rand_data(), bad_pct);
    end
  endtask

  task automatic check_word(input string name, input bus_word_t exp, input bus_word_t act);
    if (act !== exp) begin
      word_errs++;
      $display("MISMATCH %s res_bus expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_flags(input string name, input flags_t exp, input flags_t act);
    if (act !== exp) begin
      flag_errs++;
      $display("MISMATCH %s flags expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_ret(input string name, input ret_t exp, input ret_t act);
    if (act !== exp) begin
      ret_errs++;
      $display("MISMATCH %s ret expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_strobe(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      strobe_errs++;
      $display("MISMATCH %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_entry(input expect_t e, input string name);
    check_strobe({name, " res_valid"}, e.res_valid, res_valid);
    check_strobe({name, " flags_valid"}, e.flags_valid, flags_valid);
    check_strobe({name, " ret_en"}, e.ret_en, ret_en);
    if (e.res_valid) begin
      check_word(name, e.res_bus, res_bus);
    end
    if (e.flags_valid) begin
      check_flags(name, e.flags, flags);
    end
    if (e.ret_en) begin
      check_ret(name, e.ret, ret);
    end
  endtask

  // outputs are settled at the falling edge
  always @(negedge clk) begin
    if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
      check_entry(exp_q.pop_front(), name_q.pop_front());
    end
  end

  initial begin
    fu_word_t da;
    fu_word_t db;
    void'($urandom(32'h3390_d02e));
    rst = 1'b1;
    en = 1'b0;
    op = '0;
    a = '0;
    b = '0;
    fwd_a = 4'hF;
    fwd_b = 4'hF;
    fwd_prev_a = 4'hF;
    fwd_prev_b = 4'hF;
    bus0 = '0;
    bus1 = '0;
    bus2 = '0;
    bus3 = '0;
    fpcsr = '0;
    csr_val = '0;
    for (int i = 0; i < `FU_NBUS; i++) begin
      bus_next[i] = '0;
      bus_cur[i] = '0;
      bus_prev[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;

    repeat (N_IDLE) idle_cycle("idle");
    for (int i = 0; i < N_LOGIC; i++) begin
      drive_cycle(1'b1, `OP_LOGIC | 8'(i % 4), make_operand(rand_data(), 0),
                  make_operand(rand_data(), 0), 4'hF, 4'hF, 4'hF, 4'hF, "logic");
    end
    drain("logic");

    for (int i = 0; i < N_FWD; i++) begin
      randomize_buses(0);
      drive_cycle(1'b1, `OP_LOGIC | 8'($urandom_range(0, 3)), make_operand(rand_data(), 0),
                  make_operand(rand_data(), 0), rand_code(), rand_code(), rand_code(),
                  rand_code(), "forward");
    end
    drain("forward");

    // invalid enable off and then on
    for (int pass = 0; pass < 2; pass++) begin
      csr_val = $urandom;
      csr_val[`CSR_EN_LSB + `EXC_INVALID] = (pass == 1);
      fpcsr <= csr_val;
      for (int i = 0; i < N_CMP; i++) begin
        da = rand_double(rand_data());
        db = rand_double(da);
        // first ordered and unordered compares put minus zero against plus zero
        if (i < 2) begin
          da[63:0] = 64'h8000_0000_0000_0000;
          db[63:0] = 64'd0;
        end
        drive_cycle(1'b1, (i % 2 == 0) ? `OP_CMP_ORD : `OP_CMP_UNORD, make_operand(da, 0),
                    make_operand(db, 0), 4'hF, 4'hF, 4'hF, 4'hF,
                    (pass == 1) ? "compare_trap" : "compare");
      end
      drain("compare");
    end

    for (int i = 0; i < N_PERR; i++) begin
      randomize_buses(25);
      drive_cycle(1'b1, rand_op(), make_operand(rand_data(), 25),
                  make_operand(rand_data(), 25), rand_code(), rand_code(), rand_code(),
                  rand_code(), "parity");
    end
    drain("parity");

    $display("errors: res_bus %0d, flags %0d, ret %0d, strobes %0d",
             word_errs, flag_errs, ret_errs, strobe_errs);
    if (word_errs + flag_errs + ret_errs + strobe_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // reset, idle, every issue and some slack for the drains
  initial begin
    repeat (RESET_CYCLES + N_IDLE + N_ISSUED + 40) @(posedge clk);
    $display("timeout: the run did not finish, %0d results still pending", exp_q.size());
    $display("Something failed");
    $finish;
  end

endmodule

/* fpu_lane.f */
+incdir+hdl
hdl/fpu_lane_pkg.sv
hdl/operand_forward.sv
hdl/op_decode.sv
hdl/fp_exec.sv
hdl/excpt_retire.sv
hdl/fpu_lane_top.sv
tests/fpu_lane_sva.sv
tests/fpu_lane_tb.sv

/* Makefile */
TOP = fpu_lane_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f fpu_lane.f -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir
